// ==== cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Memory sizing and reset values shared by the pipeline and its testbench

// Instruction memory word address width
// 256 words of program space
`define CPU_IMEM_AW 8

// Data memory word address width
// Byte address bits above this range are ignored
`define CPU_DMEM_AW 8

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Instruction encodings
   ////////////////////////////////////////////////////////////////////////////

   // Primary opcode field
   typedef enum logic [5:0] {
      R    = 6'h00,
      J    = 6'h02,
      JAL  = 6'h03,
      BEQ  = 6'h04,
      ADDI = 6'h08,
      LW   = 6'h23,
      SW   = 6'h2b
   } opcodeE;

   // ALU control codes
   typedef enum logic [2:0] {
      AND = 3'd0,
      OR  = 3'd1,
      ADD = 3'd2,
      SUB = 3'd6,
      SLT = 3'd7
   } aluOpE;

   typedef struct packed {
      opcodeE     opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } rFieldsS;

   typedef struct packed {
      opcodeE      opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
   } iFieldsS;

   // Same instruction word seen as register or immediate format
   typedef union packed {
      rFieldsS r;
      iFieldsS i;
   } instrU;

   ////////////////////////////////////////////////////////////////////////////
   // Pipeline registers and hazard control
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic       regWrite;
      logic       memToReg;
      logic       memWrite;
      logic       aluSrc;
      // 0 selects rt, 1 selects rd, 2 selects the link register
      logic [1:0] regDst;
      aluOpE      aluOp;
      logic       jumpLink;
   } ctrlS;

   typedef struct packed {
      instrU       instr;
      logic [31:0] pcPlus4;
   } ifIdS;

   typedef struct packed {
      ctrlS        ctrl;
      logic [31:0] rd1;
      logic [31:0] rd2;
      logic [31:0] signImm;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [31:0] pcPlus4;
   } idExS;

   typedef struct packed {
      logic        regWrite;
      logic        memToReg;
      logic        memWrite;
      logic        jumpLink;
      logic [31:0] aluOut;
      logic [31:0] writeData;
      logic [4:0]  writeReg;
      logic [31:0] pcPlus4;
   } exMemS;

   typedef struct packed {
      logic        regWrite;
      logic        memToReg;
      logic        jumpLink;
      logic [31:0] readData;
      logic [31:0] aluOut;
      logic [4:0]  writeReg;
      logic [31:0] pcPlus4;
   } memWbS;

   typedef enum logic [1:0] {
      NONE     = 2'b00,
      FROM_WB  = 2'b01,
      FROM_MEM = 2'b10
   } fwdSelE;

   typedef struct packed {
      logic   stallF;
      logic   stallD;
      logic   flushE;
      logic   forwardAD;
      logic   forwardBD;
      fwdSelE forwardAE;
      fwdSelE forwardBE;
   } hazardS;

   // Destination register of an instruction in execute
   function automatic logic [4:0] destReg(input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [1:0] regDst);
      case (regDst)
         2'd0:    return rt;
         2'd1:    return rd;
         default: return 5'd31;
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module fetchStage (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    imemWe,
   input  logic [`CPU_IMEM_AW-1:0] imemAddr,
   input  logic [31:0]             imemData,
   input  logic                    stallF,
   input  logic                    stallD,
   input  logic                    pcSrc,
   input  logic [31:0]             pcTarget,
   output cpu_pkg::ifIdS           ifId
);

   logic [31:0] imem [2**`CPU_IMEM_AW];

   logic [31:0]             pc;
   logic [31:0]             pcPlus4;
   logic [31:0]             pcNext;
   logic [`CPU_IMEM_AW-1:0] imemIdx;
   logic [31:0]             instrF;

   // Program load port
   always_ff @(posedge clk) begin
      if (imemWe) begin
         imem[imemAddr] <= imemData;
      end
   end

   // Word addressed read
   assign imemIdx = pc[`CPU_IMEM_AW+1:2];
   assign instrF  = imem[imemIdx];

   assign pcPlus4 = pc + 32'd4;
   assign pcNext  = pcSrc ? pcTarget : pcPlus4;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= `CPU_RESET_PC;
      end else if (!stallF) begin
         pc <= pcNext;
      end
   end

   // IF/ID register
   // Redirect squashes the instruction fetched behind the branch
   always_ff @(posedge clk) begin
      if (rst) begin
         ifId <= '0;
      end else if (!stallD) begin
         if (pcSrc) begin
            ifId <= '0;
         end else begin
            ifId.instr   <= cpu_pkg::instrU'(instrF);
            ifId.pcPlus4 <= pcPlus4;
         end
      end
   end

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
   input  logic             clk,
   input  logic             rst,
   input  cpu_pkg::ifIdS    ifId,
   input  cpu_pkg::hazardS  hz,
   input  logic [31:0]      memFwd,
   input  logic [4:0]       wbReg,
   input  logic [31:0]      wbData,
   input  logic             wbWe,
   output logic             pcSrc,
   output logic [31:0]      pcTarget,
   output cpu_pkg::idExS    idEx
);

   logic [31:0] rf [32];

   cpu_pkg::ctrlS ctrlD;
   logic          branchD;
   logic          jumpD;
   logic [31:0]   rd1;
   logic [31:0]   rd2;
   logic [31:0]   cmpA;
   logic [31:0]   cmpB;
   logic [31:0]   signImm;

   ////////////////////////////////////////////////////////////////////////////
   // Control decode
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      ctrlD   = '0;
      branchD = 1'b0;
      jumpD   = 1'b0;
      case (ifId.instr.r.opcode)
         cpu_pkg::R: begin
            ctrlD.regWrite = 1'b1;
            ctrlD.regDst   = 2'd1;
            case (ifId.instr.r.funct)
               6'h20:   ctrlD.aluOp = cpu_pkg::ADD;
               6'h22:   ctrlD.aluOp = cpu_pkg::SUB;
               6'h24:   ctrlD.aluOp = cpu_pkg::AND;
               6'h25:   ctrlD.aluOp = cpu_pkg::OR;
               6'h2a:   ctrlD.aluOp = cpu_pkg::SLT;
               // Unknown funct behaves as a nop
               default: ctrlD.regWrite = 1'b0;
            endcase
         end
         cpu_pkg::ADDI: begin
            ctrlD.regWrite = 1'b1;
            ctrlD.aluSrc   = 1'b1;
            ctrlD.aluOp    = cpu_pkg::ADD;
         end
         cpu_pkg::LW: begin
            ctrlD.regWrite = 1'b1;
            ctrlD.memToReg = 1'b1;
            ctrlD.aluSrc   = 1'b1;
            ctrlD.aluOp    = cpu_pkg::ADD;
         end
         cpu_pkg::SW: begin
            ctrlD.memWrite = 1'b1;
            ctrlD.aluSrc   = 1'b1;
            ctrlD.aluOp    = cpu_pkg::ADD;
         end
         cpu_pkg::BEQ: branchD = 1'b1;
         cpu_pkg::J:   jumpD = 1'b1;
         cpu_pkg::JAL: begin
            jumpD          = 1'b1;
            ctrlD.regWrite = 1'b1;
            ctrlD.regDst   = 2'd2;
            ctrlD.jumpLink = 1'b1;
         end
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Register file
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wbWe) begin
         rf[wbReg] <= wbData;
      end
   end

   // Write-then-read within one cycle through the bypass
   function automatic logic [31:0] readReg(input logic [4:0] addr);
      if (addr == 5'd0) begin
         return 32'd0;
      end else if (wbWe && (addr == wbReg)) begin
         return wbData;
      end
      return rf[addr];
   endfunction

   assign rd1 = readReg(ifId.instr.r.rs);
   assign rd2 = readReg(ifId.instr.r.rt);

   assign signImm = {{16{ifId.instr.i.imm[15]}}, ifId.instr.i.imm};

   // Early branch resolution
   assign cmpA  = hz.forwardAD ? memFwd : rd1;
   assign cmpB  = hz.forwardBD ? memFwd : rd2;
   assign pcSrc = ((branchD && (cmpA == cmpB)) || jumpD) && !hz.stallD;

   assign pcTarget = jumpD ? {ifId.pcPlus4[31:28], ifId.instr.i.rs, ifId.instr.i.rt,
                              ifId.instr.i.imm, 2'b00}
                           : ifId.pcPlus4 + {signImm[29:0], 2'b00};

   // ID/EX register
   always_ff @(posedge clk) begin
      if (rst || hz.flushE) begin
         idEx <= '0;
      end else begin
         idEx.ctrl    <= ctrlD;
         idEx.rd1     <= rd1;
         idEx.rd2     <= rd2;
         idEx.signImm <= signImm;
         idEx.rs      <= ifId.instr.r.rs;
         idEx.rt      <= ifId.instr.r.rt;
         idEx.rd      <= ifId.instr.r.rd;
         idEx.pcPlus4 <= ifId.pcPlus4;
      end
   end

endmodule

`default_nettype wire

// ==== hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
   input  cpu_pkg::ifIdS    ifId,
   input  cpu_pkg::idExS    idEx,
   input  cpu_pkg::exMemS   exMem,
   input  logic [4:0]       wbReg,
   input  logic             wbWe,
   output cpu_pkg::hazardS  hz
);

   cpu_pkg::opcodeE opD;
   logic [4:0]      rsD;
   logic [4:0]      rtD;
   logic [4:0]      writeRegE;
   logic            useRs;
   logic            useRt;
   logic            lwStall;
   logic            branchStall;

   // Memory stage wins over writeback
   function automatic cpu_pkg::fwdSelE selFwd(input logic [4:0] src);
      if ((src != 5'd0) && exMem.regWrite && (src == exMem.writeReg)) begin
         return cpu_pkg::FROM_MEM;
      end else if (wbWe && (src == wbReg)) begin
         return cpu_pkg::FROM_WB;
      end
      return cpu_pkg::NONE;
   endfunction

   assign opD = ifId.instr.r.opcode;
   assign rsD = ifId.instr.r.rs;
   assign rtD = ifId.instr.r.rt;

   // Source operands actually read by the decode instruction
   assign useRs = opD inside {cpu_pkg::R, cpu_pkg::ADDI, cpu_pkg::LW, cpu_pkg::SW, cpu_pkg::BEQ};
   assign useRt = opD inside {cpu_pkg::R, cpu_pkg::SW, cpu_pkg::BEQ};

   assign writeRegE = cpu_pkg::destReg(idEx.rt, idEx.rd, idEx.ctrl.regDst);

   assign lwStall = idEx.ctrl.memToReg && (idEx.rt != 5'd0) &&
                    ((useRs && (rsD == idEx.rt)) || (useRt && (rtD == idEx.rt)));

   // Branch waits until its operands can come from the memory stage
   assign branchStall = (opD == cpu_pkg::BEQ) &&
      ((idEx.ctrl.regWrite && (writeRegE != 5'd0) &&
        ((rsD == writeRegE) || (rtD == writeRegE))) ||
       (exMem.memToReg && (exMem.writeReg != 5'd0) &&
        ((rsD == exMem.writeReg) || (rtD == exMem.writeReg))));

   always_comb begin
      hz.stallD    = lwStall || branchStall;
      hz.stallF    = hz.stallD;
      hz.flushE    = hz.stallD;
      hz.forwardAD = (rsD != 5'd0) && exMem.regWrite && (rsD == exMem.writeReg);
      hz.forwardBD = (rtD != 5'd0) && exMem.regWrite && (rtD == exMem.writeReg);
      hz.forwardAE = selFwd(idEx.rs);
      hz.forwardBE = selFwd(idEx.rt);
   end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
   input  logic             clk,
   input  logic             rst,
   input  cpu_pkg::idExS    idEx,
   input  cpu_pkg::hazardS  hz,
   input  logic [31:0]      memFwd,
   input  logic [31:0]      wbData,
   output cpu_pkg::exMemS   exMem
);

   logic [31:0]    srcA;
   logic [31:0]    srcB;
   logic [31:0]    writeData;
   logic [31:0]    aluOut;
   cpu_pkg::exMemS exMemD;

   function automatic logic [31:0] fwdMux(input cpu_pkg::fwdSelE sel,
                                          input logic [31:0] regVal);
      case (sel)
         cpu_pkg::FROM_WB:  return wbData;
         cpu_pkg::FROM_MEM: return memFwd;
         default:           return regVal;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Operand select and ALU
   ////////////////////////////////////////////////////////////////////////////

   assign srcA      = fwdMux(hz.forwardAE, idEx.rd1);
   assign writeData = fwdMux(hz.forwardBE, idEx.rd2);
   assign srcB      = idEx.ctrl.aluSrc ? idEx.signImm : writeData;

   always_comb begin
      case (idEx.ctrl.aluOp)
         cpu_pkg::AND: aluOut = srcA & srcB;
         cpu_pkg::OR:  aluOut = srcA | srcB;
         cpu_pkg::SUB: aluOut = srcA - srcB;
         // Signed compare
         cpu_pkg::SLT: aluOut = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
         default:      aluOut = srcA + srcB;
      endcase
   end

   always_comb begin
      exMemD.regWrite  = idEx.ctrl.regWrite;
      exMemD.memToReg  = idEx.ctrl.memToReg;
      exMemD.memWrite  = idEx.ctrl.memWrite;
      exMemD.jumpLink  = idEx.ctrl.jumpLink;
      exMemD.aluOut    = aluOut;
      exMemD.writeData = writeData;
      exMemD.writeReg  = cpu_pkg::destReg(idEx.rt, idEx.rd, idEx.ctrl.regDst);
      exMemD.pcPlus4   = idEx.pcPlus4;
   end

   // EX/MEM register
   always_ff @(posedge clk) begin
      if (rst) begin
         exMem <= '0;
      end else begin
         exMem <= exMemD;
      end
   end

endmodule

`default_nettype wire

// ==== memWriteback.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module memWriteback (
   input  logic            clk,
   input  logic            rst,
   input  cpu_pkg::exMemS  exMem,
   output logic [4:0]      wbReg,
   output logic [31:0]     wbData,
   output logic            wbWe,
   output logic            memWrValid,
   output logic [31:0]     memWrAddr,
   output logic [31:0]     memWrData
);

   logic [31:0] dmem [2**`CPU_DMEM_AW];

   logic [`CPU_DMEM_AW-1:0] dmemIdx;
   logic [31:0]             readData;
   cpu_pkg::memWbS          memWb;

   ////////////////////////////////////////////////////////////////////////////
   // Memory stage
   ////////////////////////////////////////////////////////////////////////////

   assign dmemIdx  = exMem.aluOut[`CPU_DMEM_AW+1:2];
   assign readData = dmem[dmemIdx];

   always_ff @(posedge clk) begin
      if (exMem.memWrite) begin
         dmem[dmemIdx] <= exMem.writeData;
      end
   end

   // Store trace
   assign memWrValid = exMem.memWrite;
   assign memWrAddr  = exMem.aluOut;
   assign memWrData  = exMem.writeData;

   // MEM/WB register
   always_ff @(posedge clk) begin
      if (rst) begin
         memWb <= '0;
      end else begin
         memWb.regWrite <= exMem.regWrite;
         memWb.memToReg <= exMem.memToReg;
         memWb.jumpLink <= exMem.jumpLink;
         memWb.readData <= readData;
         memWb.aluOut   <= exMem.aluOut;
         memWb.writeReg <= exMem.writeReg;
         memWb.pcPlus4  <= exMem.pcPlus4;
      end
   end

   // Link address takes precedence for jal
   assign wbData = memWb.jumpLink ? memWb.pcPlus4 :
                   memWb.memToReg ? memWb.readData : memWb.aluOut;
   assign wbReg  = memWb.writeReg;
   assign wbWe   = memWb.regWrite && (memWb.writeReg != 5'd0);

endmodule

`default_nettype wire

// ==== cpu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    imemWe,
   input  logic [`CPU_IMEM_AW-1:0] imemAddr,
   input  logic [31:0]             imemData,
   output logic                    wbValid,
   output logic [4:0]              wbReg,
   output logic [31:0]             wbData,
   output logic                    memWrValid,
   output logic [31:0]             memWrAddr,
   output logic [31:0]             memWrData
);

   cpu_pkg::ifIdS   ifId;
   cpu_pkg::idExS   idEx;
   cpu_pkg::exMemS  exMem;
   cpu_pkg::hazardS hz;

   logic        pcSrc;
   logic [31:0] pcTarget;
   logic [31:0] memFwd;
   logic        wbWe;

   // Result of the memory stage instruction as seen by forwarding
   assign memFwd  = exMem.jumpLink ? exMem.pcPlus4 : exMem.aluOut;
   assign wbValid = wbWe;

   ////////////////////////////////////////////////////////////////////////////
   // Pipeline stages
   ////////////////////////////////////////////////////////////////////////////

   fetchStage iFetch (
      .clk      (clk),
      .rst      (rst),
      .imemWe   (imemWe),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .stallF   (hz.stallF),
      .stallD   (hz.stallD),
      .pcSrc    (pcSrc),
      .pcTarget (pcTarget),
      .ifId     (ifId)
   );

   decodeStage iDecode (
      .clk      (clk),
      .rst      (rst),
      .ifId     (ifId),
      .hz       (hz),
      .memFwd   (memFwd),
      .wbReg    (wbReg),
      .wbData   (wbData),
      .wbWe     (wbWe),
      .pcSrc    (pcSrc),
      .pcTarget (pcTarget),
      .idEx     (idEx)
   );

   hazardUnit iHazard (
      .ifId  (ifId),
      .idEx  (idEx),
      .exMem (exMem),
      .wbReg (wbReg),
      .wbWe  (wbWe),
      .hz    (hz)
   );

   executeStage iExecute (
      .clk    (clk),
      .rst    (rst),
      .idEx   (idEx),
      .hz     (hz),
      .memFwd (memFwd),
      .wbData (wbData),
      .exMem  (exMem)
   );

   memWriteback iMemWb (
      .clk        (clk),
      .rst        (rst),
      .exMem      (exMem),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .wbWe       (wbWe),
      .memWrValid (memWrValid),
      .memWrAddr  (memWrAddr),
      .memWrData  (memWrData)
   );

endmodule

`default_nettype wire

// ==== cpu_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

// Pipeline control checks on the hazard unit outputs and the pipeline registers
module cpu_asserts (
   input logic            clk,
   input logic            rst,
   input cpu_pkg::hazardS hz,
   input cpu_pkg::ifIdS   ifId,
   input cpu_pkg::idExS   idEx,
   input logic            pcSrc,
   input logic            wbValid
);

   logic [2:0] sinceReset;

   // Saturating count of cycles out of reset
   always_ff @(posedge clk) begin
      if (rst) begin
         sinceReset <= '0;
      end else if (sinceReset != 3'd7) begin
         sinceReset <= sinceReset + 3'd1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Properties
   ////////////////////////////////////////////////////////////////////////////

   flushBubble: assert property (@(posedge clk) disable iff (rst)
      hz.flushE |=> !idEx.ctrl.regWrite)
      else $error("flushed ID/EX slot carries regWrite");

   // PC and IF/ID hold together through a decode stall
   stallPair: assert property (@(posedge clk) disable iff (rst)
      hz.stallD ##1 (!hz.stallD && !pcSrc) |=>
         (ifId.pcPlus4 == $past(ifId.pcPlus4) + 32'd4))
      else $error("fetch advanced during a decode stall");

   stallFlush: assert property (@(posedge clk) disable iff (rst)
      hz.stallD |=> (idEx.ctrl == '0))
      else $error("decode stall left an instruction in execute");

   // Pipeline fill takes four edges
   noEarlyRetire: assert property (@(posedge clk) disable iff (rst)
      (sinceReset < 3'd4) |-> !wbValid)
      else $error("retirement too soon after reset");

endmodule

bind cpu cpu_asserts iAsserts (
   .clk     (clk),
   .rst     (rst),
   .hz      (hz),
   .ifId    (ifId),
   .idEx    (idEx),
   .pcSrc   (pcSrc),
   .wbValid (wbValid)
);

`default_nettype wire

// ==== cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu_tb;

   localparam int clkPeriod = 100;
   localparam int stimDepth = 256;
   localparam int headerLen = 3;

   // Expected trace entry with the register or address first
   typedef struct packed {
      logic [31:0] tag;
      logic [31:0] value;
   } traceEntryS;

   logic                    clk;
   logic                    rst;
   logic                    imemWe;
   logic [`CPU_IMEM_AW-1:0] imemAddr;
   logic [31:0]             imemData;
   logic                    wbValid;
   logic [4:0]              wbReg;
   logic [31:0]             wbData;
   logic                    memWrValid;
   logic [31:0]             memWrAddr;
   logic [31:0]             memWrData;

   logic [31:0] stim [stimDepth];
   traceEntryS  wbQ [$];
   traceEntryS  storeQ [$];
   traceEntryS  expEntry;
   int          progLen;
   int          valueErrors;
   int          otherErrors;
   logic        running;

   cpu i_dut (
      .clk        (clk),
      .rst        (rst),
      .imemWe     (imemWe),
      .imemAddr   (imemAddr),
      .imemData   (imemData),
      .wbValid    (wbValid),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .memWrValid (memWrValid),
      .memWrAddr  (memWrAddr),
      .memWrData  (memWrData)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   task automatic checkValue(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         valueErrors++;
         $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      end
   endtask

   // Header words give the section lengths and the pairs follow the program
   task automatic loadStim();
      int wbLen;
      int storeLen;
      int base;
      $readmemh("cpu_stim.txt", stim);
      progLen  = stim[0];
      wbLen    = stim[1];
      storeLen = stim[2];
      base     = headerLen + progLen;
      for (int k = 0; k < wbLen; k++) begin
         wbQ.push_back(traceEntryS'({stim[base + 2 * k], stim[base + 2 * k + 1]}));
      end
      base = base + 2 * wbLen;
      for (int k = 0; k < storeLen; k++) begin
         storeQ.push_back(traceEntryS'({stim[base + 2 * k], stim[base + 2 * k + 1]}));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Trace monitor sampled mid-cycle
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (!rst && wbValid === 1'b1) begin
         if (wbQ.size() == 0) begin
            otherErrors++;
            $display("Unexpected retirement at %0t: r%0d written with %h",
                     $time, wbReg, wbData);
         end else begin
            expEntry = wbQ.pop_front();
            checkValue("writeback register", {27'd0, wbReg}, expEntry.tag);
            checkValue("writeback data", wbData, expEntry.value);
         end
      end
      if (!rst && memWrValid === 1'b1) begin
         if (storeQ.size() == 0) begin
            otherErrors++;
            $display("Unexpected store at %0t: address %h data %h",
                     $time, memWrAddr, memWrData);
         end else begin
            expEntry = storeQ.pop_front();
            checkValue("store address", memWrAddr, expEntry.tag);
            checkValue("store data", memWrData, expEntry.value);
         end
      end
   end

   // Watchdog scaled to the program length
   initial begin
      wait (running);
      repeat (20 * progLen + 50) @(posedge clk);
      $display("Timeout: program did not finish, %0d writebacks and %0d stores missing",
               wbQ.size(), storeQ.size());
      foreach (wbQ[k]) begin
         $display("  missing writeback r%0d = %h", wbQ[k].tag, wbQ[k].value);
      end
      foreach (storeQ[k]) begin
         $display("  missing store %h = %h", storeQ[k].tag, storeQ[k].value);
      end
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      int extraCycles;
      rst         = 1'b1;
      imemWe      = 1'b0;
      imemAddr    = '0;
      imemData    = '0;
      running     = 1'b0;
      valueErrors = 0;
      otherErrors = 0;
      void'($urandom(32'hc4c));
      extraCycles = $urandom_range(3);
      loadStim();

      // Program load while the core is held in reset
      for (int k = 0; k < progLen; k++) begin
         @(posedge clk);
         imemWe   <= 1'b1;
         imemAddr <= `CPU_IMEM_AW'(k);
         imemData <= stim[headerLen + k];
      end
      @(posedge clk);
      imemWe <= 1'b0;
      repeat (4 + extraCycles) @(posedge clk);
      rst     <= 1'b0;
      running = 1'b1;

      while (wbQ.size() != 0 || storeQ.size() != 0) begin
         @(posedge clk);
      end
      // Quiet window to catch late or extra retirements
      repeat (10) @(posedge clk);
      $display("Done: %0d value errors, %0d other errors", valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== cpu_stim.txt ====
// Header: program words, writeback pairs, store pairs (hex counts)
// Then program words, writeback pairs (reg value), store pairs (address data)
18 0d 02
// Program, one word per line from address 0
20010005 // addi r1, r0, 5
20020003 // addi r2, r0, 3
00221820 // add  r3, r1, r2
00612022 // sub  r4, r3, r1
00642824 // and  r5, r3, r4
00643025 // or   r6, r3, r4
0083382a // slt  r7, r4, r3
ac030010 // sw   r3, 16(r0)
8c080010 // lw   r8, 16(r0)
01084820 // add  r9, r8, r8
200a0010 // addi r10, r0, 16
11490001 // beq  r10, r9, taken
200b0063 // addi r11, r0, 99 skipped
10220001 // beq  r1, r2, not taken
200c0007 // addi r12, r0, 7
0c000012 // jal  word 18
200d0001 // addi r13, r0, 1 skipped
200d0002 // addi r13, r0, 2 skipped
20000009 // addi r0, r0, 9
001f7020 // add  r14, r0, r31
08000016 // j    word 22
200f004d // addi r15, r0, 77 skipped
ac0e0014 // sw   r14, 20(r0)
08000017 // j    self
// Writebacks in retirement order
00000001 00000005
00000002 00000003
00000003 00000008
00000004 00000003
00000005 00000000
00000006 0000000b
00000007 00000001
00000008 00000008
00000009 00000010
0000000a 00000010
0000000c 00000007
0000001f 00000040
0000000e 00000040
// Stores
00000010 00000008
00000014 00000040

// ==== cpu.f ====
+incdir+.
cpu_pkg.sv
fetchStage.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memWriteback.sv
cpu.sv
cpu_asserts.sv
cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard *.sv *.svh) $(FILELIST)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
